/* rv_pipe_ctrl.f */
logic/rv_isa_pkg.sv
logic/ctrl_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/sys_decoder.sv
logic/branch_resolver.sv
logic/stage_reg.sv
logic/rv_pipe_ctrl.sv
sim/rv_pipe_ctrl_chk.sv
sim/rv_pipe_ctrl_tb.sv

/* Bender.yml */
package:
  name: rv_pipe_ctrl

sources:
  - files:
      - logic/rv_isa_pkg.sv
      - logic/ctrl_pkg.sv
      - logic/main_decoder.sv
      - logic/alu_decoder.sv
      - logic/sys_decoder.sv
      - logic/branch_resolver.sv
      - logic/stage_reg.sv
      - logic/rv_pipe_ctrl.sv
  - target: simulation
    files:
      - sim/rv_pipe_ctrl_chk.sv
      - sim/rv_pipe_ctrl_tb.sv

/* sim/rv_pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_ctrl_tb;

  import ctrl_pkg::*;

  localparam int MAX_ROWS = 48;
  localparam int RST_CYCLES = 5;
  // jalr writes rd and selects PC_JALR unless reset holds the stages
  localparam logic [31:0] RST_INST = 32'h000100E7;
  localparam logic [31:0] NOP_INST = 32'h00000013;

  logic clk, i_rst, i_e_zero, i_e_neg, i_e_negu, i_e_flush;
  logic [31:0] i_d_inst;
  imm_src_t o_d_imm_src;
  logic o_d_jal, o_d_ecall, o_d_mret, o_d_illegal;
  alu_ctrl_t o_e_alu_ctrl;
  logic o_e_alu_src, o_e_imm_plus_src, o_e_ecall;
  pc_src_t o_e_pc_src;
  result_src_t o_e_result_src, o_m_result_src, o_w_result_src;
  logic o_m_mem_req, o_m_mem_write, o_m_load_signed, o_m_reg_write, o_w_reg_write;
  mem_size_t o_m_mem_size;

  // row flags apply while that row sits in EX
  string       t_name [MAX_ROWS];
  logic [31:0] t_inst [MAX_ROWS];
  logic        t_flush[MAX_ROWS];
  logic [2:0]  t_flags[MAX_ROWS];
  imm_src_t    t_imm  [MAX_ROWS];
  logic [3:0]  t_dbits[MAX_ROWS];
  alu_ctrl_t   t_alu  [MAX_ROWS];
  logic        t_asrc [MAX_ROWS];
  logic        t_ips  [MAX_ROWS];
  pc_src_t     t_pc   [MAX_ROWS];
  mem_ctrl_t   t_mem  [MAX_ROWS];
  int          num_rows = 0;
  logic        table_ready = 1'b0;
  integer      seed = 32'h82922034;

  rv_pipe_ctrl rv_pipe_ctrl_i (.*);

  bind rv_pipe_ctrl rv_pipe_ctrl_chk rv_pipe_ctrl_chk_i (.*);

  always #10 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_imm(input string n, input imm_src_t e, input imm_src_t a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  task automatic check_alu(input string n, input alu_ctrl_t e, input alu_ctrl_t a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  task automatic check_pc_src(input string n, input pc_src_t e, input pc_src_t a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  task automatic check_result_src(input string n, input result_src_t e, input result_src_t a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  task automatic check_mem(input string n, input mem_ctrl_t e, input mem_ctrl_t a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  task automatic check_wb(input string n, input wb_ctrl_t e, input wb_ctrl_t a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  task automatic check_bit(input string n, input logic e, input logic a);
    if (e !== a) report_failure($sformatf("Mismatch %s expected %0h actual %0h", n, e, a));
  endtask

  // taken rule for the six compare kinds
  // flags packed as {zero, neg, negu}
  function automatic logic branch_taken(input logic [2:0] f3, input logic [2:0] fl);
    case (f3)
      3'b000:  return fl[2];
      3'b001:  return ~fl[2];
      3'b100:  return fl[1];
      3'b101:  return ~fl[1];
      3'b110:  return fl[0];
      3'b111:  return ~fl[0];
      default: return 1'b0;
    endcase
  endfunction

  // dbits is {jal, ecall, mret, illegal}
  task automatic add_row(input string n, input logic [31:0] inst, input logic fl,
                         input logic rnd, input logic [2:0] flags, input imm_src_t imm,
                         input logic [3:0] dbits, input alu_ctrl_t alu, input logic asrc,
                         input logic ips, input pc_src_t pc, input mem_ctrl_t mem);
    t_name[num_rows]  = n;
    t_inst[num_rows]  = inst;
    t_flush[num_rows] = fl;
    t_flags[num_rows] = rnd ? 3'($random(seed)) : flags;
    t_imm[num_rows]   = imm;
    t_dbits[num_rows] = dbits;
    t_alu[num_rows]   = alu;
    t_asrc[num_rows]  = asrc;
    t_ips[num_rows]   = ips;
    t_pc[num_rows]    = pc;
    if (rnd) begin
      t_pc[num_rows] = branch_taken(inst[14:12], t_flags[num_rows]) ? PC_BRANCH : PC_PLUS4;
    end
    t_mem[num_rows]   = mem;
    num_rows++;
  endtask

  task automatic fill_table();
    mem_ctrl_t alu_wr, none;
    alu_wr = '{1'b0, 1'b0, MEM_BYTE, 1'b0, '{RES_ALU, 1'b1}};
    none   = '0;
    add_row("addi", 32'h00500093, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4, alu_wr);
    add_row("addi_b30", 32'h40008093, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4, alu_wr);
    add_row("add", 32'h002081B3, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 0, 0, PC_PLUS4, alu_wr);
    add_row("sub", 32'h402081B3, 0, 0, 0, IMM_I, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, alu_wr);
    add_row("srl", 32'h0020D1B3, 0, 0, 0, IMM_I, 4'b0000, ALU_SRL, 0, 0, PC_PLUS4, alu_wr);
    add_row("sra", 32'h4020D1B3, 0, 0, 0, IMM_I, 4'b0000, ALU_SRA, 0, 0, PC_PLUS4, alu_wr);
    add_row("srai", 32'h4020D193, 0, 0, 0, IMM_I, 4'b0000, ALU_SRA, 1, 0, PC_PLUS4, alu_wr);
    add_row("lw", 32'h00412083, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b0, 1'b1, MEM_WORD, 1'b1, '{RES_MEM, 1'b1}});
    add_row("lbu", 32'h00414083, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b0, 1'b1, MEM_BYTE, 1'b0, '{RES_MEM, 1'b1}});
    add_row("lh", 32'h00411083, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b0, 1'b1, MEM_HALF, 1'b1, '{RES_MEM, 1'b1}});
    add_row("sw", 32'h00112423, 0, 0, 0, IMM_S, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b1, 1'b1, MEM_WORD, 1'b0, '{RES_ALU, 1'b0}});
    add_row("sb", 32'h00110423, 0, 0, 0, IMM_S, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b1, 1'b1, MEM_BYTE, 1'b0, '{RES_ALU, 1'b0}});
    add_row("beq_t", 32'h00208063, 0, 0, 3'b100, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_BRANCH, none);
    add_row("beq_n", 32'h00208063, 0, 0, 3'b011, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("beq_r", 32'h00208063, 0, 1, 0, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("bne_r", 32'h00209063, 0, 1, 0, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("blt_r", 32'h0020C063, 0, 1, 0, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("bge_r", 32'h0020D063, 0, 1, 0, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("bltu_r", 32'h0020E063, 0, 1, 0, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("bgeu_r", 32'h0020F063, 0, 1, 0, IMM_B, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, none);
    add_row("jal", 32'h000000EF, 0, 0, 0, IMM_J, 4'b1000, ALU_ADD, 0, 0, PC_PLUS4,
            '{1'b0, 1'b0, MEM_BYTE, 1'b0, '{RES_PC4, 1'b1}});
    add_row("jalr", 32'h000100E7, 0, 0, 3'b111, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_JALR,
            '{1'b0, 1'b0, MEM_BYTE, 1'b0, '{RES_PC4, 1'b1}});
    add_row("lui", 32'h123450B7, 0, 0, 0, IMM_U, 4'b0000, ALU_ADD, 0, 0, PC_PLUS4,
            '{1'b0, 1'b0, MEM_BYTE, 1'b0, '{RES_IMM, 1'b1}});
    add_row("auipc", 32'h12345097, 0, 0, 0, IMM_U, 4'b0000, ALU_ADD, 0, 1, PC_PLUS4,
            '{1'b0, 1'b0, MEM_BYTE, 1'b0, '{RES_IMM, 1'b1}});
    add_row("ecall", 32'h00000073, 0, 0, 3'b100, IMM_I, 4'b0100, ALU_ADD, 0, 0, PC_TRAP, none);
    add_row("mret", 32'h30200073, 0, 0, 0, IMM_I, 4'b0010, ALU_ADD, 0, 0, PC_PLUS4, none);
    add_row("csrrw", 32'h30001073, 0, 0, 0, IMM_I, 4'b0001, ALU_ADD, 0, 0, PC_PLUS4, none);
    add_row("bad_op", 32'h0000007F, 0, 0, 0, IMM_I, 4'b0001, ALU_ADD, 0, 0, PC_PLUS4, none);
    add_row("bad_ld", 32'h00413083, 0, 0, 0, IMM_I, 4'b0001, ALU_ADD, 0, 0, PC_PLUS4, none);
    add_row("bad_st", 32'h00113423, 0, 0, 0, IMM_S, 4'b0001, ALU_ADD, 0, 0, PC_PLUS4, none);
    add_row("pre_fl", 32'h00412083, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b0, 1'b1, MEM_WORD, 1'b1, '{RES_MEM, 1'b1}});
    add_row("flushed", 32'h00112423, 1, 0, 0, IMM_S, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4,
            '{1'b1, 1'b1, MEM_WORD, 1'b0, '{RES_ALU, 1'b0}});
    add_row("post_fl", 32'h402081B3, 0, 0, 0, IMM_I, 4'b0000, ALU_SUB, 0, 0, PC_PLUS4, alu_wr);
    // drain so the last real rows reach WB
    repeat (3) begin
      add_row("nop", NOP_INST, 0, 0, 0, IMM_I, 4'b0000, ALU_ADD, 1, 0, PC_PLUS4, alu_wr);
    end
    table_ready = 1'b1;
  endtask

  task automatic check_reset_state(input string n);
    check_bit({n, " m_mem_req"}, 1'b0, o_m_mem_req);
    check_bit({n, " m_mem_write"}, 1'b0, o_m_mem_write);
    check_bit({n, " m_reg_write"}, 1'b0, o_m_reg_write);
    check_bit({n, " w_reg_write"}, 1'b0, o_w_reg_write);
    check_pc_src({n, " e_pc_src"}, PC_PLUS4, o_e_pc_src);
  endtask

  initial begin : watchdog
    time limit;
    wait (table_ready);
    limit = (num_rows + 10 + RST_CYCLES) * 20;
    #(limit);
    report_failure("Timeout: the run did not reach its end in time");
  end

  // bound assertions raise this count
  initial begin : assertion_watch
    wait (rv_pipe_ctrl_i.rv_pipe_ctrl_chk_i.fail_count != 0);
    report_failure("A bound checker assertion failed");
  end

  initial begin : main
    mem_ctrl_t exp_mem, act_mem;
    int j;
    clk = 1'b0;
    i_rst = 1'b1;
    i_d_inst = RST_INST;
    i_e_zero = 1'b0;
    i_e_neg = 1'b0;
    i_e_negu = 1'b0;
    i_e_flush = 1'b0;
    fill_table();
    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_reset_state("reset");
    @(posedge clk);
    i_rst <= 1'b0;
    i_d_inst <= NOP_INST;
    for (int i = 0; i < num_rows; i++) begin
      @(posedge clk);
      i_d_inst  <= t_inst[i];
      i_e_flush <= t_flush[i];
      if (i > 0) begin
        {i_e_zero, i_e_neg, i_e_negu} <= t_flags[i-1];
      end
      @(negedge clk);
      if (i == 0) begin
        check_reset_state("after_reset");
      end
      check_imm({t_name[i], " d_imm_src"}, t_imm[i], o_d_imm_src);
      check_bit({t_name[i], " d_jal"}, t_dbits[i][3], o_d_jal);
      check_bit({t_name[i], " d_ecall"}, t_dbits[i][2], o_d_ecall);
      check_bit({t_name[i], " d_mret"}, t_dbits[i][1], o_d_mret);
      check_bit({t_name[i], " d_illegal"}, t_dbits[i][0], o_d_illegal);
      if (i >= 1) begin
        j = i - 1;
        exp_mem = t_flush[j] ? '0 : t_mem[j];
        check_alu({t_name[j], " e_alu_ctrl"}, t_flush[j] ? ALU_ADD : t_alu[j], o_e_alu_ctrl);
        check_bit({t_name[j], " e_alu_src"}, t_asrc[j] & ~t_flush[j], o_e_alu_src);
        check_bit({t_name[j], " e_imm_plus"}, t_ips[j] & ~t_flush[j], o_e_imm_plus_src);
        check_bit({t_name[j], " e_ecall"}, t_dbits[j][2] & ~t_flush[j], o_e_ecall);
        check_pc_src({t_name[j], " e_pc_src"}, t_flush[j] ? PC_PLUS4 : t_pc[j], o_e_pc_src);
        check_result_src({t_name[j], " e_result_src"}, exp_mem.wb.result_src,
                         o_e_result_src);
      end
      if (i >= 2) begin
        j = i - 2;
        exp_mem = t_flush[j] ? '0 : t_mem[j];
        act_mem = '{o_m_mem_write, o_m_mem_req, o_m_mem_size, o_m_load_signed,
                    '{o_m_result_src, o_m_reg_write}};
        check_mem({t_name[j], " m_ctrl"}, exp_mem, act_mem);
      end
      if (i >= 3) begin
        j = i - 3;
        exp_mem = t_flush[j] ? '0 : t_mem[j];
        check_wb({t_name[j], " w_ctrl"}, exp_mem.wb, '{o_w_result_src, o_w_reg_write});
      end
    end
    if (rv_pipe_ctrl_i.rv_pipe_ctrl_chk_i.fail_count != 0) begin
      report_failure("A bound checker assertion failed");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim/rv_pipe_ctrl_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_ctrl_chk (
  input wire logic                 clk,
  input wire logic                 i_rst,
  input wire logic                 i_e_flush,
  input wire logic                 o_d_ecall,
  input wire ctrl_pkg::alu_ctrl_t  o_e_alu_ctrl,
  input wire logic                 o_e_alu_src,
  input wire logic                 o_e_imm_plus_src,
  input wire logic                 o_e_ecall,
  input wire ctrl_pkg::pc_src_t    o_e_pc_src,
  input wire ctrl_pkg::result_src_t o_e_result_src,
  input wire logic                 o_m_mem_req,
  input wire logic                 o_m_mem_write,
  input wire logic                 o_m_reg_write,
  input wire logic                 o_w_reg_write
);

  import ctrl_pkg::*;

  // count of failed assertions
  int fail_count = 0;

  // write enables cleared one edge after reset is seen
  reset_clears_writes: assert property (@(posedge clk)
    i_rst |=> (!o_m_mem_req && !o_m_mem_write && !o_m_reg_write && !o_w_reg_write))
    else begin
      fail_count++;
      $error("write enable active after reset");
    end

  // a flushed ID/EX stage holds a bubble
  flush_clears_ex: assert property (@(posedge clk) disable iff (i_rst)
    i_e_flush |=> (o_e_alu_ctrl == ALU_ADD && !o_e_alu_src && !o_e_imm_plus_src
                   && !o_e_ecall && o_e_result_src == RES_ALU))
    else begin
      fail_count++;
      $error("EX controls not cleared after flush");
    end

  // trap vector only for an ecall decoded in D one cycle earlier and not flushed
  trap_needs_ecall: assert property (@(posedge clk) disable iff (i_rst)
    (o_e_pc_src == PC_TRAP) |-> (o_e_ecall && $past(o_d_ecall) && !$past(i_e_flush)))
    else begin
      fail_count++;
      $error("trap vector selected without ecall");
    end

endmodule

`default_nettype wire

/* logic/rv_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_ctrl (
  input  wire logic                clk,
  input  wire logic                i_rst,
  input  wire logic [31:0]         i_d_inst,
  input  wire logic                i_e_zero,
  input  wire logic                i_e_neg,
  input  wire logic                i_e_negu,
  // from hazard unit
  input  wire logic                i_e_flush,
  output ctrl_pkg::imm_src_t       o_d_imm_src,
  output logic                     o_d_jal,
  output logic                     o_d_ecall,
  output logic                     o_d_mret,
  output logic                     o_d_illegal,
  output ctrl_pkg::alu_ctrl_t      o_e_alu_ctrl,
  output logic                     o_e_alu_src,
  output logic                     o_e_imm_plus_src,
  output logic                     o_e_ecall,
  output ctrl_pkg::pc_src_t        o_e_pc_src,
  output ctrl_pkg::result_src_t    o_e_result_src,
  output logic                     o_m_mem_req,
  output logic                     o_m_mem_write,
  output ctrl_pkg::mem_size_t      o_m_mem_size,
  output logic                     o_m_load_signed,
  output ctrl_pkg::result_src_t    o_m_result_src,
  output logic                     o_m_reg_write,
  output ctrl_pkg::result_src_t    o_w_result_src,
  output logic                     o_w_reg_write
);

  import ctrl_pkg::*;

  // instruction fields
  logic [6:0]  d_opcode;
  logic [2:0]  d_funct3;
  logic [11:0] d_funct12;
  logic        d_funct7_b5;

  // decode outputs
  logic        d_reg_write, d_alu_src, d_mem_req, d_mem_write;
  logic        d_load_signed, d_imm_plus_src, d_branch, d_jalr, d_system;
  logic        d_main_illegal, d_sys_illegal;
  alu_op_t     d_alu_op;
  mem_size_t   d_mem_size;
  result_src_t d_result_src;
  alu_ctrl_t   d_alu_ctrl;

  ex_ctrl_t    d_ex, e_ex;
  mem_ctrl_t   m_mem;
  wb_ctrl_t    w_wb;

  assign d_opcode    = i_d_inst[6:0];
  assign d_funct3    = i_d_inst[14:12];
  assign d_funct12   = i_d_inst[31:20];
  assign d_funct7_b5 = i_d_inst[30];

  main_decoder main_decoder_i (
    .i_opcode(d_opcode), .i_funct3(d_funct3),
    .o_reg_write(d_reg_write), .o_alu_src(d_alu_src),
    .o_mem_req(d_mem_req), .o_mem_write(d_mem_write),
    .o_load_signed(d_load_signed), .o_imm_plus_src(d_imm_plus_src),
    .o_branch(d_branch), .o_jal(o_d_jal), .o_jalr(d_jalr),
    .o_system(d_system), .o_imm_src(o_d_imm_src), .o_alu_op(d_alu_op),
    .o_mem_size(d_mem_size), .o_result_src(d_result_src),
    .o_illegal(d_main_illegal)
  );

  alu_decoder alu_decoder_i (
    .i_alu_op(d_alu_op), .i_funct3(d_funct3),
    .i_opcode_b5(d_opcode[5]), .i_funct7_b5(d_funct7_b5),
    .o_alu_ctrl(d_alu_ctrl)
  );

  sys_decoder sys_decoder_i (
    .i_system(d_system), .i_funct3(d_funct3), .i_funct12(d_funct12),
    .o_ecall(o_d_ecall), .o_mret(o_d_mret), .o_illegal(d_sys_illegal)
  );

  assign o_d_illegal = d_main_illegal | d_sys_illegal;

  // illegal instructions enter EX as a bubble, trap logic takes it from D
  always_comb begin
    d_ex.alu_ctrl           = d_alu_ctrl;
    d_ex.alu_src            = d_alu_src;
    d_ex.imm_plus_src       = d_imm_plus_src;
    d_ex.ecall              = o_d_ecall;
    d_ex.funct3             = d_funct3;
    d_ex.branch             = d_branch;
    d_ex.jalr               = d_jalr;
    d_ex.mem.mem_write      = d_mem_write;
    d_ex.mem.mem_req        = d_mem_req;
    d_ex.mem.mem_size       = d_mem_size;
    d_ex.mem.load_signed    = d_load_signed;
    d_ex.mem.wb.result_src  = d_result_src;
    d_ex.mem.wb.reg_write   = d_reg_write;
    if (o_d_illegal) begin
      d_ex = '0;
    end
  end

  stage_reg #(.T(ex_ctrl_t)) id_ex_i (
    .clk(clk), .i_rst(i_rst), .i_clear(i_e_flush), .i_d(d_ex), .o_q(e_ex)
  );

  branch_resolver branch_resolver_i (
    .i_branch(e_ex.branch), .i_jalr(e_ex.jalr), .i_ecall(e_ex.ecall),
    .i_funct3(e_ex.funct3), .i_zero(i_e_zero), .i_neg(i_e_neg),
    .i_negu(i_e_negu), .o_pc_src(o_e_pc_src)
  );

  stage_reg #(.T(mem_ctrl_t)) ex_mem_i (
    .clk(clk), .i_rst(i_rst), .i_clear(1'b0), .i_d(e_ex.mem), .o_q(m_mem)
  );

  stage_reg #(.T(wb_ctrl_t)) mem_wb_i (
    .clk(clk), .i_rst(i_rst), .i_clear(1'b0), .i_d(m_mem.wb), .o_q(w_wb)
  );

  assign o_e_alu_ctrl     = e_ex.alu_ctrl;
  assign o_e_alu_src      = e_ex.alu_src;
  assign o_e_imm_plus_src = e_ex.imm_plus_src;
  assign o_e_ecall        = e_ex.ecall;
  assign o_e_result_src   = e_ex.mem.wb.result_src;

  assign o_m_mem_req      = m_mem.mem_req;
  assign o_m_mem_write    = m_mem.mem_write;
  assign o_m_mem_size     = m_mem.mem_size;
  assign o_m_load_signed  = m_mem.load_signed;
  assign o_m_result_src   = m_mem.wb.result_src;
  assign o_m_reg_write    = m_mem.wb.reg_write;

  assign o_w_result_src   = w_wb.result_src;
  assign o_w_reg_write    = w_wb.reg_write;

endmodule

`default_nettype wire

/* logic/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type T = logic
) (
  input  wire logic clk,
  input  wire logic i_rst,
  input  wire logic i_clear,
  input  wire T     i_d,
  output T          o_q
);

  // clear turns the stage into a bubble
  always_ff @(posedge clk) begin
    if (i_rst || i_clear) begin
      o_q <= '0;
    end else begin
      o_q <= i_d;
    end
  end

endmodule

`default_nettype wire

/* logic/branch_resolver.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
  input  wire logic       i_branch,
  input  wire logic       i_jalr,
  input  wire logic       i_ecall,
  input  wire logic [2:0] i_funct3,
  input  wire logic       i_zero,
  input  wire logic       i_neg,
  input  wire logic       i_negu,
  output ctrl_pkg::pc_src_t o_pc_src
);

  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  logic taken;

  // flags come from rs1 - rs2 in the alu
  always_comb begin
    case (i_funct3)
      F3_BEQ:  taken = i_zero;
      F3_BNE:  taken = ~i_zero;
      F3_BLT:  taken = i_neg;
      F3_BGE:  taken = ~i_neg;
      F3_BLTU: taken = i_negu;
      F3_BGEU: taken = ~i_negu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ecall) begin
      o_pc_src = PC_TRAP;
    end else if (i_jalr) begin
      o_pc_src = PC_JALR;
    end else if (i_branch && taken) begin
      o_pc_src = PC_BRANCH;
    end else begin
      o_pc_src = PC_PLUS4;
    end
  end

endmodule

`default_nettype wire

/* logic/sys_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_decoder (
  input  wire logic        i_system,
  input  wire logic [2:0]  i_funct3,
  input  wire logic [11:0] i_funct12,
  output logic             o_ecall,
  output logic             o_mret,
  output logic             o_illegal
);

  import rv_isa_pkg::*;

  logic priv;

  // privileged group only, csr ops fall through as illegal
  assign priv = i_system & (i_funct3 == 3'b000);

  assign o_ecall   = priv & (i_funct12 == F12_ECALL);
  assign o_mret    = priv & (i_funct12 == F12_MRET);
  assign o_illegal = i_system & ~(o_ecall | o_mret);

endmodule

`default_nettype wire

/* logic/alu_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
  input  wire ctrl_pkg::alu_op_t   i_alu_op,
  input  wire logic [2:0]          i_funct3,
  input  wire logic                i_opcode_b5,
  input  wire logic                i_funct7_b5,
  output ctrl_pkg::alu_ctrl_t      o_alu_ctrl
);

  import ctrl_pkg::*;

  logic is_sub;

  // addi has no sub form, imm bits land in funct7
  assign is_sub = i_opcode_b5 & i_funct7_b5;

  always_comb begin
    case (i_alu_op)
      ALUOP_ADD: o_alu_ctrl = ALU_ADD;
      ALUOP_SUB: o_alu_ctrl = ALU_SUB;
      ALUOP_FUNCT: begin
        case (i_funct3)
          3'b000:  o_alu_ctrl = is_sub ? ALU_SUB : ALU_ADD;
          3'b001:  o_alu_ctrl = ALU_SLL;
          3'b010:  o_alu_ctrl = ALU_SLT;
          3'b011:  o_alu_ctrl = ALU_SLTU;
          3'b100:  o_alu_ctrl = ALU_XOR;
          // srai carries the same bit 30 as sra
          3'b101:  o_alu_ctrl = i_funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  o_alu_ctrl = ALU_OR;
          default: o_alu_ctrl = ALU_AND;
        endcase
      end
      default: o_alu_ctrl = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

/* logic/main_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
  input  wire logic [6:0]          i_opcode,
  input  wire logic [2:0]          i_funct3,
  output logic                     o_reg_write,
  output logic                     o_alu_src,
  output logic                     o_mem_req,
  output logic                     o_mem_write,
  output logic                     o_load_signed,
  output logic                     o_imm_plus_src,
  output logic                     o_branch,
  output logic                     o_jal,
  output logic                     o_jalr,
  output logic                     o_system,
  output ctrl_pkg::imm_src_t       o_imm_src,
  output ctrl_pkg::alu_op_t        o_alu_op,
  output ctrl_pkg::mem_size_t      o_mem_size,
  output ctrl_pkg::result_src_t    o_result_src,
  output logic                     o_illegal
);

  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  always_comb begin
    // defaults describe a bubble
    o_reg_write    = 1'b0;
    o_alu_src      = 1'b0;
    o_mem_req      = 1'b0;
    o_mem_write    = 1'b0;
    o_load_signed  = 1'b0;
    o_imm_plus_src = 1'b0;
    o_branch       = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_system       = 1'b0;
    o_imm_src      = IMM_I;
    o_alu_op       = ALUOP_ADD;
    o_mem_size     = MEM_BYTE;
    o_result_src   = RES_ALU;
    o_illegal      = 1'b0;

    case (i_opcode)
      OP_LOAD: begin
        o_alu_src    = 1'b1;
        o_result_src = RES_MEM;
        case (i_funct3)
          F3_LB:  o_mem_size = MEM_BYTE;
          F3_LH:  o_mem_size = MEM_HALF;
          F3_LW:  o_mem_size = MEM_WORD;
          F3_LBU: o_mem_size = MEM_BYTE;
          F3_LHU: o_mem_size = MEM_HALF;
          default: o_illegal = 1'b1;
        endcase
        // only the unsigned forms have funct3[2] set
        o_load_signed = ~i_funct3[2] & ~o_illegal;
        o_mem_req     = ~o_illegal;
        o_reg_write   = ~o_illegal;
      end
      OP_STORE: begin
        o_alu_src = 1'b1;
        o_imm_src = IMM_S;
        case (i_funct3)
          F3_LB:  o_mem_size = MEM_BYTE;
          F3_LH:  o_mem_size = MEM_HALF;
          F3_LW:  o_mem_size = MEM_WORD;
          default: o_illegal = 1'b1;
        endcase
        o_mem_req   = ~o_illegal;
        o_mem_write = ~o_illegal;
      end
      OP_OP: begin
        o_reg_write = 1'b1;
        o_alu_op    = ALUOP_FUNCT;
      end
      OP_OP_IMM: begin
        o_reg_write = 1'b1;
        o_alu_src   = 1'b1;
        o_alu_op    = ALUOP_FUNCT;
      end
      OP_BRANCH: begin
        o_imm_src = IMM_B;
        o_branch  = 1'b1;
        o_alu_op  = ALUOP_SUB;
      end
      OP_JAL: begin
        o_reg_write  = 1'b1;
        o_imm_src    = IMM_J;
        o_jal        = 1'b1;
        o_result_src = RES_PC4;
      end
      OP_JALR: begin
        o_reg_write  = 1'b1;
        o_alu_src    = 1'b1;
        o_jalr       = 1'b1;
        o_result_src = RES_PC4;
      end
      OP_LUI: begin
        o_reg_write  = 1'b1;
        o_imm_src    = IMM_U;
        o_result_src = RES_IMM;
      end
      OP_AUIPC: begin
        // immediate plus pc
        o_reg_write    = 1'b1;
        o_imm_src      = IMM_U;
        o_imm_plus_src = 1'b1;
        o_result_src   = RES_IMM;
      end
      OP_SYSTEM: o_system = 1'b1;
      default:   o_illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* logic/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_src_t;

  // add for address calc, sub for compares, funct for arithmetic
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'd0,
    ALUOP_SUB   = 2'd1,
    ALUOP_FUNCT = 2'd2
  } alu_op_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_ctrl_t;

  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_size_t;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2,
    RES_IMM = 2'd3
  } result_src_t;

  typedef enum logic [1:0] {
    PC_PLUS4  = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JALR   = 2'd2,
    PC_TRAP   = 2'd3
  } pc_src_t;

  // MEM/WB payload
  typedef struct packed {
    result_src_t result_src;
    logic        reg_write;
  } wb_ctrl_t;

  // EX/MEM payload
  typedef struct packed {
    logic      mem_write;
    logic      mem_req;
    mem_size_t mem_size;
    logic      load_signed;
    wb_ctrl_t  wb;
  } mem_ctrl_t;

  // ID/EX payload, 20 bits
  typedef struct packed {
    alu_ctrl_t  alu_ctrl;
    logic       alu_src;
    logic       imm_plus_src;
    logic       ecall;
    logic [2:0] funct3;
    logic       branch;
    logic       jalr;
    mem_ctrl_t  mem;
  } ex_ctrl_t;

endpackage

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // base opcodes, inst[6:0]
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // branch compare kinds
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load widths, stores share the low three codes
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // system, inst[31:20] with funct3 zero
  localparam logic [11:0] F12_ECALL = 12'h000;
  localparam logic [11:0] F12_MRET  = 12'h302;

endpackage

`default_nettype wire
